// File: bp_csr.sv
`timescale 1ns/1ps
`default_nettype none

module bp_csr (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [31:0]                 wb_adr,
    input  wire [31:0]                 wb_dat_w,
    input  wire [3:0]                  wb_sel,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    input  wire branch_pkg::redirect_t redirect,
    output branch_pkg::bp_ctrl_t       ctrl
);

    logic        req;
    logic        wr_ctrl;
    logic [31:0] rd_data;

    logic        pred_en_q;
    logic        clear_q;
    logic [31:0] br_cnt_q;
    logic [31:0] miss_cnt_q;

    // New request only, master still holds stb during the ack cycle
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr_ctrl = req && wb_we && wb_sel[0] && (wb_adr == branch_pkg::REG_CTRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_en_q <= 1'b1;                 // Prediction on out of reset
            clear_q   <= 1'b0;
        end else begin
            clear_q <= wr_ctrl && wb_dat_w[branch_pkg::CTRL_CLEAR];
            if (wr_ctrl) begin
                pred_en_q <= wb_dat_w[branch_pkg::CTRL_PRED_EN];
            end
        end
    end

    // Statistics, wrap at 2^32
    always_ff @(posedge clk) begin
        if (rst || clear_q) begin
            br_cnt_q   <= '0;
            miss_cnt_q <= '0;
        end else begin
            if (redirect.resolved) begin
                br_cnt_q <= br_cnt_q + 32'd1;
            end
            if (redirect.mispredict) begin
                miss_cnt_q <= miss_cnt_q + 32'd1;
            end
        end
    end

    always_comb begin
        rd_data = '0;                          // Unmapped offsets read zero
        case (wb_adr)
            branch_pkg::REG_CTRL:     rd_data[branch_pkg::CTRL_PRED_EN] = pred_en_q;
            branch_pkg::REG_BR_CNT:   rd_data = br_cnt_q;
            branch_pkg::REG_MISS_CNT: rd_data = miss_cnt_q;
            default:                  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;               // Valid while wb_ack high
        end
    end

    assign ctrl.pred_en = pred_en_q;
    assign ctrl.clear   = clear_q;

endmodule

`default_nettype wire

// File: branch_pkg.sv
`default_nettype none

package branch_pkg;

    // Branch type encodings as in instruction bits 29:26
    typedef enum logic [3:0] {
        NONE = 4'b0000,
        JIRL = 4'b0011,
        B    = 4'b0100,
        BL   = 4'b0101,
        BEQ  = 4'b0110,
        BNE  = 4'b0111,
        BLT  = 4'b1000,
        BGE  = 4'b1001,
        BLTU = 4'b1010,
        BGEU = 4'b1011
    } br_type_e;

    // Branch target buffer geometry
    localparam int BTB_IDX_W = 4;                  // 16 entries
    localparam int BTB_TAG_W = 26;                 // pc[31:6]
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;

    // Register map of the predictor control block
    localparam logic [31:0] REG_CTRL     = 32'h0;
    localparam logic [31:0] REG_BR_CNT   = 32'h4;
    localparam logic [31:0] REG_MISS_CNT = 32'h8;

    localparam int CTRL_PRED_EN = 0;               // Bit positions in REG_CTRL
    localparam int CTRL_CLEAR   = 1;

    // Branch record as seen by the execute stage
    typedef struct packed {
        logic        valid;
        br_type_e    br_type;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic        pred_taken;
        logic [31:0] pred_target;
    } ex_branch_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;                       // pc + 4 when not taken
    } resolve_t;

    typedef struct packed {
        logic        valid;                        // Mispredict, fetch must restart
        logic [31:0] target;
        logic        train_en;
        logic [31:0] train_pc;
        logic [31:0] train_target;
        logic        resolved;                     // Statistics events
        logic        mispredict;
    } redirect_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] target;
    } fetch_pred_t;

    typedef struct packed {
        logic pred_en;
        logic clear;
    } bp_ctrl_t;

endpackage

`default_nettype wire

// File: branch_sys.sv
`timescale 1ns/1ps
`default_nettype none

module branch_sys (
    input  wire                         clk,
    input  wire                         rst,
    input  wire branch_pkg::ex_branch_t ex,
    input  wire [31:0]                  fetch_pc,
    input  wire                         wb_cyc,
    input  wire                         wb_stb,
    input  wire                         wb_we,
    input  wire [31:0]                  wb_adr,
    input  wire [31:0]                  wb_dat_w,
    input  wire [3:0]                   wb_sel,
    output branch_pkg::redirect_t       redirect,
    output branch_pkg::fetch_pred_t     fetch_pred,
    output logic [31:0]                 wb_dat_r,
    output logic                        wb_ack
);

    branch_pkg::resolve_t res;
    branch_pkg::bp_ctrl_t ctrl;

    branch_unit u_branch_unit (
        .ex  (ex),
        .res (res)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk      (clk),
        .rst      (rst),
        .ex       (ex),
        .res      (res),
        .redirect (redirect)
    );

    btb u_btb (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .fetch_pc   (fetch_pc),
        .redirect   (redirect),
        .fetch_pred (fetch_pred)
    );

    bp_csr u_bp_csr (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .redirect (redirect),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// File: branch_sys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module branch_sys_asserts (
    input wire                          clk,
    input wire                          rst,
    input wire branch_pkg::ex_branch_t  ex,
    input wire [31:0]                   fetch_pc,
    input wire                          wb_cyc,
    input wire                          wb_stb,
    input wire                          wb_we,
    input wire [31:0]                   wb_adr,
    input wire [31:0]                   wb_dat_w,
    input wire [31:0]                   wb_dat_r,
    input wire                          wb_ack,
    input wire branch_pkg::redirect_t   redirect,
    input wire branch_pkg::fetch_pred_t fetch_pred
);

    branch_pkg::ex_branch_t last_ex;           // Record sampled at the previous edge
    logic [32:0]            act;               // {taken, next pc}
    logic                   exp_redirect;
    logic                   new_req;
    logic                   ctrl_wr;
    logic                   req_q;
    logic                   pred_en_q;
    logic                   clear_q;
    logic [15:0]            sh_valid;
    logic [25:0]            sh_tag    [16];
    logic [31:0]            sh_target [16];
    logic [31:0]            br_cnt;
    logic [31:0]            miss_cnt;
    logic                   exp_hit;
    logic [31:0]            exp_target;
    logic [31:0]            exp_rdata;
    int                     err_count;

    function automatic logic [32:0] resolve(input branch_pkg::ex_branch_t r);
        logic taken;
        case (r.br_type)
            branch_pkg::JIRL, branch_pkg::B, branch_pkg::BL: taken = 1'b1;
            branch_pkg::BEQ:  taken = r.rdata1 == r.rdata2;
            branch_pkg::BNE:  taken = r.rdata1 != r.rdata2;
            branch_pkg::BLT:  taken = $signed(r.rdata1) < $signed(r.rdata2);
            branch_pkg::BGE:  taken = $signed(r.rdata1) >= $signed(r.rdata2);
            branch_pkg::BLTU: taken = r.rdata1 < r.rdata2;
            branch_pkg::BGEU: taken = r.rdata1 >= r.rdata2;
            default:          taken = 1'b0;
        endcase
        if (!taken) begin
            return {1'b0, r.pc + 32'd4};
        end
        return {1'b1, (r.br_type == branch_pkg::JIRL ? r.rdata1 : r.pc) + r.imm};
    endfunction

    assign act          = resolve(last_ex);
    assign exp_redirect = last_ex.valid && ((act[32] != last_ex.pred_taken) ||
                          (act[32] && act[31:0] != last_ex.pred_target));
    assign new_req      = wb_cyc && wb_stb && !req_q;   // Master holds through the ack cycle
    assign ctrl_wr      = new_req && wb_we && (wb_adr == branch_pkg::REG_CTRL);

    initial err_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_ex   <= '0;
            req_q     <= 1'b0;
            pred_en_q <= 1'b1;
            clear_q   <= 1'b0;
            sh_valid  <= '0;
            br_cnt    <= '0;
            miss_cnt  <= '0;
            exp_hit   <= 1'b0;
        end else begin
            last_ex <= ex;
            req_q   <= new_req;
            clear_q <= ctrl_wr && wb_dat_w[1];
            if (ctrl_wr) begin
                pred_en_q <= wb_dat_w[0];
            end
            if (clear_q) begin
                sh_valid <= '0;
                br_cnt   <= '0;
                miss_cnt <= '0;
            end else begin
                if (last_ex.valid && act[32]) begin    // Index pc[5:2], tag pc[31:6]
                    sh_valid[last_ex.pc[5:2]]  <= 1'b1;
                    sh_tag[last_ex.pc[5:2]]    <= last_ex.pc[31:6];
                    sh_target[last_ex.pc[5:2]] <= act[31:0];
                end
                if (last_ex.valid) begin
                    br_cnt <= br_cnt + 32'd1;
                end
                if (exp_redirect) begin
                    miss_cnt <= miss_cnt + 32'd1;
                end
            end
            exp_hit    <= pred_en_q && sh_valid[fetch_pc[5:2]] &&
                          (sh_tag[fetch_pc[5:2]] == fetch_pc[31:6]);
            exp_target <= sh_target[fetch_pc[5:2]];
            if (new_req) begin
                case (wb_adr)
                    branch_pkg::REG_CTRL:     exp_rdata <= {31'd0, pred_en_q};
                    branch_pkg::REG_BR_CNT:   exp_rdata <= br_cnt;
                    branch_pkg::REG_MISS_CNT: exp_rdata <= miss_cnt;
                    default:                  exp_rdata <= '0;
                endcase
            end
        end
    end

    a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
        redirect.valid == exp_redirect)
        else begin
            $error("CHECK FAILED t=%0t redirect.valid got %b exp %b",
                   $time, redirect.valid, exp_redirect);
            err_count++;
        end

    a_redirect_target: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> redirect.target == act[31:0])
        else begin
            $error("CHECK FAILED t=%0t redirect.target got %h exp %h",
                   $time, redirect.target, act[31:0]);
            err_count++;
        end

    a_events: assert property (@(posedge clk) disable iff (rst)
        {redirect.resolved, redirect.mispredict, redirect.train_en} ==
        {last_ex.valid, exp_redirect, last_ex.valid && act[32]})
        else begin
            $error("CHECK FAILED t=%0t redirect events got %b exp %b", $time,
                   {redirect.resolved, redirect.mispredict, redirect.train_en},
                   {last_ex.valid, exp_redirect, last_ex.valid && act[32]});
            err_count++;
        end

    a_train: assert property (@(posedge clk) disable iff (rst)
        redirect.train_en |-> {redirect.train_pc, redirect.train_target} ==
        {last_ex.pc, act[31:0]})
        else begin
            $error("CHECK FAILED t=%0t redirect.train got %h %h exp %h %h", $time,
                   redirect.train_pc, redirect.train_target, last_ex.pc, act[31:0]);
            err_count++;
        end

    a_fetch_hit: assert property (@(posedge clk) disable iff (rst)
        fetch_pred.hit == exp_hit)
        else begin
            $error("CHECK FAILED t=%0t fetch_pred.hit got %b exp %b",
                   $time, fetch_pred.hit, exp_hit);
            err_count++;
        end

    a_fetch_target: assert property (@(posedge clk) disable iff (rst)
        fetch_pred.hit |-> fetch_pred.target == exp_target)
        else begin
            $error("CHECK FAILED t=%0t fetch_pred.target got %h exp %h",
                   $time, fetch_pred.target, exp_target);
            err_count++;
        end

    a_wb_ack: assert property (@(posedge clk) disable iff (rst)
        wb_ack == req_q)
        else begin
            $error("CHECK FAILED t=%0t wb_ack got %b exp %b", $time, wb_ack, req_q);
            err_count++;
        end

    a_wb_rdata: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && !wb_we) |-> wb_dat_r == exp_rdata)
        else begin
            $error("CHECK FAILED t=%0t wb_dat_r got %h exp %h", $time, wb_dat_r, exp_rdata);
            err_count++;
        end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire branch_pkg::ex_branch_t ex,
    output branch_pkg::resolve_t        res
);

    logic        eq;
    logic        lt_s;
    logic        lt_u;
    logic [31:0] pc_rel;
    logic [31:0] reg_rel;
    logic [31:0] seq_pc;

    assign eq      = ex.rdata1 == ex.rdata2;
    assign lt_s    = $signed(ex.rdata1) < $signed(ex.rdata2);
    assign lt_u    = ex.rdata1 < ex.rdata2;
    assign pc_rel  = ex.pc + ex.imm;           // B, BL and conditional branches
    assign reg_rel = ex.rdata1 + ex.imm;       // JIRL only
    assign seq_pc  = ex.pc + 32'd4;

    always_comb begin
        res.taken  = 1'b0;                     // Fall through by default
        res.target = seq_pc;
        case (ex.br_type)
            branch_pkg::JIRL: begin
                res.taken  = 1'b1;
                res.target = reg_rel;
            end
            branch_pkg::B,
            branch_pkg::BL: begin
                res.taken  = 1'b1;
                res.target = pc_rel;
            end
            branch_pkg::BEQ: begin
                if (eq) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            branch_pkg::BNE: begin
                if (!eq) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            branch_pkg::BLT: begin
                if (lt_s) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            branch_pkg::BGE: begin
                if (!lt_s) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            branch_pkg::BLTU: begin
                if (lt_u) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            branch_pkg::BGEU: begin
                if (!lt_u) begin
                    res.taken  = 1'b1;
                    res.target = pc_rel;
                end
            end
            default: begin                     // NONE and unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  wire                        clk,
    input  wire                        rst,
    input  wire branch_pkg::bp_ctrl_t  ctrl,
    input  wire [31:0]                 fetch_pc,
    input  wire branch_pkg::redirect_t redirect,
    output branch_pkg::fetch_pred_t    fetch_pred
);

    logic [branch_pkg::BTB_DEPTH-1:0] valid_q;
    logic [branch_pkg::BTB_TAG_W-1:0] tag_mem    [branch_pkg::BTB_DEPTH];
    logic [31:0]                      target_mem [branch_pkg::BTB_DEPTH];

    logic [branch_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [branch_pkg::BTB_TAG_W-1:0] wr_tag;
    logic [branch_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [branch_pkg::BTB_TAG_W-1:0] rd_tag;
    logic                             rd_match;

    logic        hit_q;
    logic [31:0] target_q;

    // pc[1:0] always zero, index just above it
    assign wr_idx = redirect.train_pc[branch_pkg::BTB_IDX_W+1:2];
    assign wr_tag = redirect.train_pc[31:branch_pkg::BTB_IDX_W+2];
    assign rd_idx = fetch_pc[branch_pkg::BTB_IDX_W+1:2];
    assign rd_tag = fetch_pc[31:branch_pkg::BTB_IDX_W+2];

    assign rd_match = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    // Entry valid bits, clear takes priority over training
    always_ff @(posedge clk) begin
        if (rst || ctrl.clear) begin
            valid_q <= '0;
        end else if (redirect.train_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.train_en) begin
            tag_mem[wr_idx]    <= wr_tag;      // Overwrite on alias
            target_mem[wr_idx] <= redirect.train_target;
        end
    end

    // Registered lookup, old array contents at a write edge
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= ctrl.pred_en && rd_match;
        end
    end

    always_ff @(posedge clk) begin
        target_q <= target_mem[rd_idx];
    end

    assign fetch_pred.hit    = hit_q;
    assign fetch_pred.target = target_q;

endmodule

`default_nettype wire

// File: redirect_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire branch_pkg::ex_branch_t ex,
    input  wire branch_pkg::resolve_t   res,
    output branch_pkg::redirect_t       redirect
);

    logic        dir_wrong;
    logic        tgt_wrong;
    logic        mispredict;
    logic [31:0] next_pc;

    logic        valid_q;
    logic        train_en_q;
    logic        resolved_q;
    logic        mispredict_q;
    logic [31:0] target_q;
    logic [31:0] train_pc_q;
    logic [31:0] train_target_q;

    assign dir_wrong  = res.taken != ex.pred_taken;
    assign tgt_wrong  = res.taken && ex.pred_taken && (res.target != ex.pred_target);
    assign mispredict = ex.valid && (dir_wrong || tgt_wrong);
    assign next_pc    = res.taken ? res.target : ex.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q      <= 1'b0;
            train_en_q   <= 1'b0;
            resolved_q   <= 1'b0;
            mispredict_q <= 1'b0;
        end else begin
            valid_q      <= mispredict;
            train_en_q   <= ex.valid && res.taken;   // Every taken branch trains
            resolved_q   <= ex.valid;
            mispredict_q <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            target_q       <= next_pc;
            train_pc_q     <= ex.pc;
            train_target_q <= res.target;
        end
    end

    assign redirect.valid        = valid_q;
    assign redirect.target       = target_q;
    assign redirect.train_en     = train_en_q;
    assign redirect.train_pc     = train_pc_q;
    assign redirect.train_target = train_target_q;
    assign redirect.resolved     = resolved_q;
    assign redirect.mispredict   = mispredict_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module tb_branch_sys -f verilog.f \
    -o sim_tb_branch_sys || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb_branch_sys +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// File: tb_branch_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_sys;

    localparam int N_COND      = 200;
    localparam int N_MISS      = 100;
    localparam int N_STATS     = 60;
    localparam int WATCHDOG_NS = (4 + N_COND + N_MISS + N_STATS + 200) * 10 + 500;

    localparam logic [31:0] TRAIN_PC  = 32'h0000_1040;
    localparam logic [31:0] TRAIN_IMM = 32'h0000_0100;

    logic                    clk = 1'b0;
    logic                    rst;
    branch_pkg::ex_branch_t  ex;
    logic [31:0]             fetch_pc;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [31:0]             wb_adr;
    logic [31:0]             wb_dat_w;
    logic [3:0]              wb_sel;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;
    branch_pkg::redirect_t   redirect;
    branch_pkg::fetch_pred_t fetch_pred;

    logic [31:0] lfsr = 32'hb440;
    int          tb_errors;
    int          tests_run;
    int          errs_before;

    branch_sys UUT (.*);

    bind branch_sys branch_sys_asserts u_asserts (.*);

    always #5 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic branch_pkg::ex_branch_t random_record(input logic guess);
        branch_pkg::ex_branch_t r;
        logic [31:0]            v;
        r.valid   = 1'b1;
        v         = rand_word(4);
        r.br_type = branch_pkg::br_type_e'(v[3:0]);   // Unused codes too
        r.pc      = rand_word(30) << 2;
        r.imm     = rand_word(16) << 2;
        if (r.imm[17]) begin
            r.imm[31:18] = '1;
        end
        r.rdata1 = rand_word(32);
        r.rdata2 = rand_word(32);
        v        = rand_word(2);
        case (v[1:0])
            2'd0: r.rdata2 = r.rdata1;                // Equal operands
            2'd1: begin                               // Negative against positive
                r.rdata1[31] = 1'b1;
                r.rdata2[31] = 1'b0;
            end
            2'd2: begin                               // Both large unsigned
                r.rdata1[31:28] = 4'hf;
                r.rdata2[31:28] = 4'hf;
            end
            default: begin
            end
        endcase
        v             = rand_word(2);
        r.pred_taken  = guess && v[0];
        r.pred_target = v[1] ? r.pc + r.imm : r.pc + r.imm + 32'd4;
        return r;
    endfunction

    task automatic send_record(input branch_pkg::ex_branch_t r);
        @(posedge clk);
        ex <= r;
    endtask

    task automatic send_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            ex <= '0;
        end
    endtask

    task automatic hold_fetch(input logic [31:0] pc, input int cycles);
        @(posedge clk);
        fetch_pc <= pc;
        repeat (cycles) @(posedge clk);
    endtask

    // Wait for the acknowledge at falling edges, then release the bus
    task automatic end_cycle(output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (wb_ack !== 1'b1 && waited < 4) begin
            waited++;
            @(negedge clk);
        end
        if (wb_ack !== 1'b1) begin
            $display("Wishbone request at address %h was never acknowledged", wb_adr);
            tb_errors++;
        end
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused_rd;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wb_sel   <= 4'hf;
        end_cycle(unused_rd);
    endtask

    task automatic read_reg(input logic [31:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        end_cycle(data);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_errors + UUT.u_asserts.err_count;
        $display("%-12s finished with %0d new errors", name, errs - errs_before);
        errs_before = errs;
        tests_run++;
    endtask

    initial begin
        branch_pkg::ex_branch_t tr;
        logic [31:0]            br_rd;
        logic [31:0]            miss_rd;
        rst         = 1'b1;
        ex          = '0;
        fetch_pc    = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        tb_errors   = 0;
        tests_run   = 0;
        errs_before = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_COND; i++) begin            // Prediction always not taken
            send_record(random_record(1'b0));
        end
        send_idle(2);
        finish_test("cond_eval");

        for (int i = 0; i < N_MISS; i++) begin
            send_record(random_record(1'b1));
        end
        send_idle(2);
        finish_test("mispredict");

        tr         = '0;
        tr.valid   = 1'b1;
        tr.br_type = branch_pkg::B;
        tr.pc      = TRAIN_PC;
        tr.imm     = TRAIN_IMM;
        send_record(tr);
        send_idle(3);
        hold_fetch(TRAIN_PC, 3);
        hold_fetch(TRAIN_PC ^ 32'h40, 3);                 // Same index, other tag
        hold_fetch(TRAIN_PC, 2);
        finish_test("btb_lookup");

        write_reg(branch_pkg::REG_CTRL, 32'h0);
        hold_fetch(TRAIN_PC, 3);
        write_reg(branch_pkg::REG_CTRL, 32'h1);
        hold_fetch(TRAIN_PC, 3);
        write_reg(branch_pkg::REG_CTRL, 32'h3);           // Clear, keep prediction on
        hold_fetch(TRAIN_PC, 3);
        finish_test("ctrl_reg");

        write_reg(branch_pkg::REG_CTRL, 32'h3);
        for (int i = 0; i < N_STATS; i++) begin
            send_record(random_record(1'b1));
        end
        send_idle(3);
        read_reg(branch_pkg::REG_BR_CNT, br_rd);
        read_reg(branch_pkg::REG_MISS_CNT, miss_rd);
        $display("statistics   %0d branches, %0d mispredicts", br_rd, miss_rd);
        write_reg(branch_pkg::REG_CTRL, 32'h3);
        read_reg(branch_pkg::REG_BR_CNT, br_rd);
        read_reg(branch_pkg::REG_MISS_CNT, miss_rd);
        read_reg(branch_pkg::REG_CTRL, br_rd);
        finish_test("statistics");

        $display("%0d tests run, %0d assertion failures, %0d other errors",
                 tests_run, UUT.u_asserts.err_count, tb_errors);
        if (tb_errors == 0 && UUT.u_asserts.err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
branch_pkg.sv
branch_unit.sv
redirect_ctrl.sv
btb.sv
bp_csr.sv
branch_sys.sv
branch_sys_asserts.sv
tb_branch_sys.sv
